/* vga_pkg.sv */
// shared types for the vga output subsystem
// channel, pixel, raster coordinate, buffer address and apb vectors
// counter phase enum for the sync generator

package vga_pkg;

  typedef logic [3:0]  color_t;     // one rgb444 channel
  typedef logic [11:0] pixel_t;     // red in 11:8, green 7:4, blue 3:0
  typedef logic [9:0]  coord_t;     // raster column or row
  typedef logic [12:0] fb_addr_t;   // 80x60 = 4800 words
  typedef logic [3:0]  apb_addr_t;  // register offset
  typedef logic [31:0] apb_data_t;

  // phases of a horizontal or vertical counter
  typedef enum logic [1:0] {
    PH_ACTIVE,
    PH_FRONT,
    PH_SYNC,
    PH_BACK
  } sync_phase_t;

endpackage

/* vga_sync.sv */
// 640x480 raster timing
// pixel enable divider, column and row counters
// registered hsync, vsync and visible flag

`timescale 1ns/1ps

module vga_sync #(
  parameter int c_pxl_div = 2
) (
  input  logic            rst,
  input  logic            clk,
  output logic            new_pxl,
  output logic            visible,
  output logic            hsync,
  output logic            vsync,
  output vga_pkg::coord_t col,
  output vga_pkg::coord_t row
);
  import vga_pkg::*;

  // phase start points, horizontal
  localparam coord_t c_h_fp_beg   = 10'd640;
  localparam coord_t c_h_sync_beg = 10'd656;
  localparam coord_t c_h_bp_beg   = 10'd752;
  localparam coord_t c_h_last     = 10'd799;
  // vertical
  localparam coord_t c_v_fp_beg   = 10'd480;
  localparam coord_t c_v_sync_beg = 10'd490;
  localparam coord_t c_v_bp_beg   = 10'd492;
  localparam coord_t c_v_last     = 10'd524;

  localparam int c_div_w = (c_pxl_div > 1) ? $clog2(c_pxl_div) : 1;

  logic [c_div_w-1:0] div_cnt;
  coord_t             col_nxt;
  coord_t             row_nxt;
  sync_phase_t        h_phase;
  sync_phase_t        v_phase;

  function automatic sync_phase_t phase_of(coord_t cnt, coord_t fp_beg, coord_t sync_beg,
                                           coord_t bp_beg);
    if (cnt < fp_beg)
      return PH_ACTIVE;
    else if (cnt < sync_beg)
      return PH_FRONT;
    else if (cnt < bp_beg)
      return PH_SYNC;
    else
      return PH_BACK;
  endfunction

  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      div_cnt <= '0;
    else if (new_pxl)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  assign new_pxl = (div_cnt == c_div_w'(c_pxl_div - 1)); // last clock of the pixel

  // next position, row steps when the line wraps
  assign col_nxt = (col == c_h_last) ? '0 : col + 1'b1;
  assign row_nxt = (col != c_h_last) ? row : (row == c_v_last) ? '0 : row + 1'b1;

  assign h_phase = phase_of(col_nxt, c_h_fp_beg, c_h_sync_beg, c_h_bp_beg);
  assign v_phase = phase_of(row_nxt, c_v_fp_beg, c_v_sync_beg, c_v_bp_beg);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      col     <= '0;
      row     <= '0;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
      visible <= 1'b0;
    end else if (new_pxl) begin
      col     <= col_nxt;
      row     <= row_nxt;
      hsync   <= (h_phase != PH_SYNC);  // active low
      vsync   <= (v_phase != PH_SYNC);
      visible <= (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE);
    end
  end

endmodule

/* frame_buffer.sv */
// frame buffer ram
// one write port from the register block, one registered read port for display

`timescale 1ns/1ps

module frame_buffer #(
  parameter int c_depth = 4800
) (
  input  logic              rst,
  input  logic              we,
  input  vga_pkg::fb_addr_t waddr,
  input  vga_pkg::pixel_t   wdata,
  input  vga_pkg::fb_addr_t raddr,
  output vga_pkg::pixel_t   rd_data
);
  import vga_pkg::*;

  pixel_t mem [c_depth];

  // write side
  always_ff @(posedge rst) begin
    if (we && (waddr < fb_addr_t'(c_depth)))
      mem[waddr] <= wdata;
  end

  // read side, one clock latency
  always_ff @(posedge rst) begin
    if (raddr < fb_addr_t'(c_depth))
      rd_data <= mem[raddr];
  end

endmodule

/* apb_regs.sv */
// apb slave for the display registers
// ctrl, auto-incrementing pixel address, pixel data port, frame counter
// drives the frame buffer write port

`timescale 1ns/1ps

module apb_regs #(
  parameter int c_depth = 4800
) (
  input  logic               rst,
  input  logic               clk,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  vga_pkg::apb_addr_t paddr,
  input  vga_pkg::apb_data_t pwdata,
  output vga_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic               vsync,
  output logic               rgbmode,
  output logic               testmode,
  output logic               fb_we,
  output vga_pkg::fb_addr_t  fb_waddr,
  output vga_pkg::pixel_t    fb_wdata
);
  import vga_pkg::*;

  localparam apb_addr_t c_reg_ctrl = 4'h0;
  localparam apb_addr_t c_reg_addr = 4'h4;
  localparam apb_addr_t c_reg_data = 4'h8;
  localparam apb_addr_t c_reg_stat = 4'hC;

  logic      access;
  logic      addr_ok;
  logic      wr;
  logic      vsync_d;
  fb_addr_t  pix_addr;
  apb_data_t frame_cnt;

  assign access = psel && penable;
  assign addr_ok = (paddr == c_reg_ctrl) || (paddr == c_reg_addr) ||
                   (paddr == c_reg_data) || (paddr == c_reg_stat);
  assign wr      = access && pwrite && addr_ok;
  assign pready  = 1'b1;                   // no wait states
  assign pslverr = access && !addr_ok;

  always_comb begin
    case (paddr)
      c_reg_ctrl: prdata = {30'd0, testmode, rgbmode};
      c_reg_addr: prdata = apb_data_t'(pix_addr);
      c_reg_stat: prdata = frame_cnt;
      default:    prdata = '0;             // data port reads as zero
    endcase
  end

  // buffer write in the access cycle of a data write
  assign fb_we    = wr && (paddr == c_reg_data);
  assign fb_waddr = pix_addr;
  assign fb_wdata = pwdata[11:0];

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rgbmode  <= 1'b0;
      testmode <= 1'b0;
      pix_addr <= '0;
    end else if (wr) begin
      if (paddr == c_reg_ctrl) begin
        rgbmode  <= pwdata[0];
        testmode <= pwdata[1];
      end
      if (paddr == c_reg_addr)
        pix_addr <= pwdata[12:0];
      if (paddr == c_reg_data)
        pix_addr <= (pix_addr == fb_addr_t'(c_depth - 1)) ? '0 : pix_addr + 1'b1;
    end
  end

  // frame count on vsync falling edge
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      vsync_d   <= 1'b1;
      frame_cnt <= '0;
    end else begin
      vsync_d <= vsync;
      if (vsync_d && !vsync)
        frame_cnt <= frame_cnt + 1'b1;
    end
  end

endmodule

/* test_pattern.sv */
// colour bar generator
// picks buffer data or bars depending on test mode

`timescale 1ns/1ps

module test_pattern #(
  parameter int c_img_cols = 80
) (
  input  logic            testmode,
  input  vga_pkg::coord_t col,
  input  vga_pkg::pixel_t rd_data,
  output vga_pkg::pixel_t frame_pixel
);
  import vga_pkg::*;

  localparam coord_t c_bar_w = coord_t'(c_img_cols / 8);  // eight bars across the image

  logic [2:0] bar;
  color_t     bar_red;
  color_t     bar_green;
  color_t     bar_blue;

  // upper bits only matter outside the image, where the pixel is not shown
  assign bar = 3'(col / c_bar_w);

  // bit 2 red, bit 1 green, bit 0 blue
  assign bar_red   = bar[2] ? 4'hF : 4'h0;
  assign bar_green = bar[1] ? 4'hF : 4'h0;
  assign bar_blue  = bar[0] ? 4'hF : 4'h0;

  assign frame_pixel = testmode ? {bar_red, bar_green, bar_blue} : rd_data;

endmodule

/* vga_display.sv */
// display pixel path
// frame buffer read addressing, guide lines at 1x 2x 4x image size
// mode glyph roms and the final colour mux

`timescale 1ns/1ps

module vga_display #(
  parameter int c_img_cols = 80,
  parameter int c_img_rows = 60
) (
  input  logic              rst,
  input  logic              clk,
  input  logic              visible,
  input  logic              new_pxl,
  input  logic              rgbmode,
  input  logic              testmode,
  input  vga_pkg::coord_t   col,
  input  vga_pkg::coord_t   row,
  input  vga_pkg::pixel_t   frame_pixel,
  output vga_pkg::fb_addr_t frame_addr,
  output vga_pkg::color_t   vga_red,
  output vga_pkg::color_t   vga_green,
  output vga_pkg::color_t   vga_blue
);
  import vga_pkg::*;

  localparam coord_t c_cols = coord_t'(c_img_cols);
  localparam coord_t c_rows = coord_t'(c_img_rows);

  logic       in_img;
  logic [2:0] char_col;
  logic [7:0] glyph_rgb;
  logic [7:0] glyph_test;

  assign in_img   = (col < c_cols) && (row < c_rows);
  assign char_col = col[2:0];

  // R when colour, Y when grey
  always_comb begin
    case ({~rgbmode, row[2:0]})
      4'h0: glyph_rgb = 8'b11111100;
      4'h1: glyph_rgb = 8'b10000010;
      4'h2: glyph_rgb = 8'b10000010;
      4'h3: glyph_rgb = 8'b11111100;
      4'h4: glyph_rgb = 8'b10001000;
      4'h5: glyph_rgb = 8'b10000100;
      4'h6: glyph_rgb = 8'b10000010;
      4'h8: glyph_rgb = 8'b10000010;
      4'h9: glyph_rgb = 8'b01000100;
      4'hA: glyph_rgb = 8'b00111000;
      4'hB, 4'hC, 4'hD, 4'hE: glyph_rgb = 8'b00010000;
      default: glyph_rgb = 8'b00000000; // blank last line
    endcase
  end

  // N normal, T test
  always_comb begin
    case ({testmode, row[2:0]})
      4'h0: glyph_test = 8'b10000010;
      4'h1: glyph_test = 8'b11000010;
      4'h2: glyph_test = 8'b10100010;
      4'h3: glyph_test = 8'b10010010;
      4'h4: glyph_test = 8'b10001010;
      4'h5: glyph_test = 8'b10000110;
      4'h6: glyph_test = 8'b10000010;
      4'h8: glyph_test = 8'b11111110;
      4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE: glyph_test = 8'b00010000;
      default: glyph_test = 8'b00000000;
    endcase
  end

  // read address follows the raster, one step per image pixel
  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      frame_addr <= '0;
    else if (row >= c_rows)
      frame_addr <= '0;
    else if ((col < c_cols) && new_pxl)
      frame_addr <= frame_addr + 1'b1;
  end

  always_comb begin
    {vga_red, vga_green, vga_blue} = 12'h000;
    if (visible) begin
      if (in_img) begin
        if (rgbmode)
          {vga_red, vga_green, vga_blue} = frame_pixel;
        else
          {vga_red, vga_green, vga_blue} = {3{frame_pixel[7:4]}}; // grey from green nibble
      end else if ((col == c_cols) || (row == c_rows))
        {vga_red, vga_green, vga_blue} = 12'h088;  // cyan
      else if ((col == 2 * c_cols) || (row == 2 * c_rows))
        {vga_red, vga_green, vga_blue} = 12'h880;  // yellow
      else if ((col == 4 * c_cols) || (row == 4 * c_rows))
        {vga_red, vga_green, vga_blue} = 12'h808;  // magenta
      else if ((row >= 10'd256) && (row < 10'd264)) begin
        if ((col >= 10'd8) && (col < 10'd16) && glyph_rgb[7 - char_col])
          {vga_red, vga_green, vga_blue} = 12'hFFF;
        else if ((col >= 10'd16) && (col < 10'd24) && glyph_test[7 - char_col])
          {vga_red, vga_green, vga_blue} = 12'hFFF;
      end
    end
  end

endmodule

/* vga_top.sv */
// top level of the video output
// raster timing, apb registers, frame buffer, test bars and display path

`timescale 1ns/1ps

module vga_top #(
  parameter int c_img_cols = 80,
  parameter int c_img_rows = 60,
  parameter int c_pxl_div  = 2
) (
  input  logic               rst,
  input  logic               clk,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  vga_pkg::apb_addr_t paddr,
  input  vga_pkg::apb_data_t pwdata,
  output vga_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               hsync,
  output logic               vsync,
  output vga_pkg::color_t    vga_red,
  output vga_pkg::color_t    vga_green,
  output vga_pkg::color_t    vga_blue
);
  import vga_pkg::*;

  localparam int c_fb_depth = c_img_cols * c_img_rows;

  logic     new_pxl;
  logic     visible;
  coord_t   col;
  coord_t   row;
  logic     rgbmode;
  logic     testmode;
  logic     fb_we;
  fb_addr_t fb_waddr;
  pixel_t   fb_wdata;
  fb_addr_t frame_addr;
  pixel_t   rd_data;
  pixel_t   frame_pixel;

  vga_sync #(.c_pxl_div(c_pxl_div)) u_sync (
    .rst, .clk, .new_pxl, .visible, .hsync, .vsync, .col, .row
  );

  apb_regs #(.c_depth(c_fb_depth)) u_regs (
    .rst, .clk, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .vsync,
    .rgbmode, .testmode, .fb_we, .fb_waddr, .fb_wdata
  );

  frame_buffer #(.c_depth(c_fb_depth)) u_fb (
    .rst, .we(fb_we), .waddr(fb_waddr), .wdata(fb_wdata),
    .raddr(frame_addr), .rd_data
  );

  test_pattern #(.c_img_cols(c_img_cols)) u_bars (
    .testmode, .col, .rd_data, .frame_pixel
  );

  vga_display #(.c_img_cols(c_img_cols), .c_img_rows(c_img_rows)) u_disp (
    .rst, .clk, .visible, .new_pxl, .rgbmode, .testmode, .col, .row,
    .frame_pixel, .frame_addr, .vga_red, .vga_green, .vga_blue
  );

endmodule

/* vga_assertions.sv */
// bound checks for vga_top
// hsync pulse width, pslverr only in access, single-clock buffer write

`timescale 1ns/1ps

module vga_assertions (
  input logic rst,
  input logic clk,
  input logic new_pxl,
  input logic hsync,
  input logic psel,
  input logic penable,
  input logic pslverr,
  input logic fb_we
);

  logic [7:0] hs_low_cnt;  // pixel periods with hsync low
  int         fail_cnt = 0;

  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      hs_low_cnt <= '0;
    else if (hsync)
      hs_low_cnt <= '0;
    else if (new_pxl)
      hs_low_cnt <= hs_low_cnt + 8'd1;
  end

  hsync_width: assert property (@(posedge rst) disable iff (clk)
    $rose(hsync) |-> hs_low_cnt == 8'd96)
    else begin
      $error("hsync low period is not 96 pixels");
      fail_cnt++;
    end

  // access is the cycle right after a setup cycle
  err_in_access: assert property (@(posedge rst) disable iff (clk)
    pslverr |-> psel && penable && $past(psel && !penable))
    else begin
      $error("pslverr outside an access cycle");
      fail_cnt++;
    end

  we_one_clock: assert property (@(posedge rst) disable iff (clk)
    fb_we |=> !fb_we)
    else begin
      $error("fb_we held longer than one clock");
      fail_cnt++;
    end

endmodule

bind vga_top vga_assertions u_assert (
  .rst(rst), .clk(clk), .new_pxl(new_pxl), .hsync(hsync),
  .psel(psel), .penable(penable), .pslverr(pslverr), .fb_we(fb_we)
);

/* tb_vga_top.sv */
// testbench for the vga output subsystem
// clock, reset, apb tasks, vector reader, raster tracker, checks and watchdog

`timescale 1ns/1ps

module tb_vga_top;
  import vga_pkg::*;

  localparam int      c_cols     = 80;
  localparam int      c_rows     = 60;
  localparam int      c_div      = 2;
  localparam longint  c_clk_ns   = 100;
  localparam longint  c_frame_ns = 800 * 525 * c_div * c_clk_ns;

  logic      rst;       // clock
  logic      clk;       // reset active high
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      hsync;
  logic      vsync;
  color_t    vga_red;
  color_t    vga_green;
  color_t    vga_blue;

  logic [63:0] vec [0:127];
  pixel_t      model [0:c_cols*c_rows-1];  // what the host wrote
  logic [31:0] lfsr = 32'h7f4ce35b;
  bit          vec_loaded;
  longint      limit_ns;
  int          tests_run;
  int          tests_failed;
  bit          test_err;

  // raster tracker state
  bit   trk_on;
  bit   trk_second;
  bit   vsync_hi;
  bit   exp_hs;
  bit   exp_vs;
  int   trk_col;
  int   trk_row;
  int   trk_frame;
  int   sync_errs;
  event sample_ev;

  vga_top #(.c_img_cols(c_cols), .c_img_rows(c_rows), .c_pxl_div(c_div)) u_dut (.*);

  initial rst = 1'b0;
  always #(c_clk_ns / 2) rst = ~rst;

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per pixel bit
  function automatic pixel_t next_pixel();
    pixel_t p;
    for (int b = 0; b < 12; b++) begin
      lfsr = lfsr_step(lfsr);
      p[b] = lfsr[0];
    end
    return p;
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    assert (got == exp) else begin
      $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, got);
      test_err = 1;
    end
  endtask

  // setup cycle then access cycle with the response sampled mid access
  task automatic apb_write(apb_addr_t a, apb_data_t d, output logic err);
    @(posedge rst);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge rst);
    penable <= 1'b1;
    @(negedge rst);
    err = pslverr;
    check_val("pready", 32'(pready), 32'd1);
    @(posedge rst);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(apb_addr_t a, output apb_data_t d, output logic err);
    @(posedge rst);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge rst);
    penable <= 1'b1;
    @(negedge rst);
    d   = prdata;
    err = pslverr;
    check_val("pready", 32'(pready), 32'd1);
    @(posedge rst);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // waits for the tracker to reach a pixel and flags it if already gone by
  task automatic wait_pixel(int f, int c, int r, output bit missed, output pixel_t seen);
    bit done;
    done   = 0;
    missed = 0;
    seen   = '0;
    while (!done) begin
      @(sample_ev);
      if (trk_frame == f && trk_row == r && trk_col == c) begin
        seen = {vga_red, vga_green, vga_blue};
        done = 1;
      end else if (trk_frame > f || (trk_frame == f &&
                   (trk_row > r || (trk_row == r && trk_col > c)))) begin
        missed = 1;
        done   = 1;
      end
    end
  endtask

  // counts pixel periods from the first vsync fall at row 490 column 0
  always @(negedge rst) begin
    if (trk_on) begin
      if (trk_second) begin
        trk_second = 0;
        if (trk_col == 799) begin
          trk_col = 0;
          if (trk_row == 524) begin
            trk_row = 0;
            trk_frame++;
          end else
            trk_row++;
        end else
          trk_col++;
      end else begin
        trk_second = 1;
        exp_hs     = !(trk_col >= 656 && trk_col <= 751);
        exp_vs     = !(trk_row == 490 || trk_row == 491);
        assert (hsync == exp_hs) else begin
          $display("ERROR t=%0t hsync expected %0b got %0b", $time, exp_hs, hsync);
          sync_errs++;
        end
        assert (vsync == exp_vs) else begin
          $display("ERROR t=%0t vsync expected %0b got %0b", $time, exp_vs, vsync);
          sync_errs++;
        end
        -> sample_ev;
      end
    end else if (!clk && vsync_hi && !vsync) begin
      trk_on     = 1;
      trk_second = 0;  // first clock of the pixel
      trk_col    = 0;
      trk_row    = 490;
    end
    vsync_hi = vsync;
  end

  initial begin
    logic [3:0]  op;
    logic [3:0]  sel;
    logic [31:0] data;
    logic [31:0] s0;
    logic        err;
    pixel_t      pix;
    pixel_t      seen;
    bit          missed;
    bit          rgb_on;
    int          ptr;
    int          col;
    int          row;
    int          frm;
    int          max_frame;
    longint      apb_ops;

    clk     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    foreach (vec[i])
      vec[i] = '0;
    $readmemh("vga_vectors.txt", vec);

    max_frame = 0;
    apb_ops   = 0;
    foreach (vec[i]) begin
      if (vec[i][63:60] == 4'h4 || vec[i][63:60] == 4'h6)
        max_frame = (int'(vec[i][59:56]) > max_frame) ? int'(vec[i][59:56]) : max_frame;
      else if (vec[i][63:60] == 4'h5)
        apb_ops += longint'(vec[i][31:0]);
      else
        apb_ops += 2;
    end
    limit_ns   = (max_frame + 2) * c_frame_ns + apb_ops * 4 * c_clk_ns;
    vec_loaded = 1;

    repeat (3) @(posedge rst);
    clk <= 1'b0;
    @(negedge rst);

    test_err = 0;
    check_val("hsync", 32'(hsync), 32'd1);
    check_val("vsync", 32'(vsync), 32'd1);
    check_val("rgb", 32'({vga_red, vga_green, vga_blue}), 32'h0);
    tests_run++;
    tests_failed += test_err;
    $display("test %0d reset state %s", tests_run, test_err ? "failed" : "ok");

    rgb_on = 0;
    ptr    = 0;
    for (int i = 0; i < 128; i++) begin
      op   = vec[i][63:60];
      sel  = vec[i][59:56];
      data = vec[i][31:0];
      col  = int'(vec[i][51:40]);
      row  = int'(vec[i][39:28]);
      frm  = int'(sel);
      if (op == 4'h0 || op == 4'hF)
        break;
      test_err = 0;
      case (op)
        4'h1: begin
          apb_write(sel, data, err);
          check_val("pslverr", 32'(err), 32'd0);
          if (sel == 4'h0)
            rgb_on = data[0];
          if (sel == 4'h4)
            ptr = int'(data[12:0]);
        end
        4'h2: begin
          apb_read(sel, s0, err);
          check_val("prdata", s0, data);
          check_val("pslverr", 32'(err), 32'd0);
        end
        4'h3: begin
          apb_read(sel, s0, err);
          check_val("pslverr", 32'(err), 32'd1);
        end
        4'h5: begin
          for (int n = 0; n < int'(data); n++) begin
            pix        = next_pixel();
            model[ptr] = pix;
            apb_write(4'h8, 32'(pix), err);
            check_val("pslverr", 32'(err), 32'd0);
            ptr = (ptr == c_cols * c_rows - 1) ? 0 : ptr + 1;
          end
        end
        4'h7: begin
          // one vsync start per tracked frame before row 490
          frm = trk_frame;
          wait (trk_frame != frm);
          apb_read(4'hC, data, err);
          check_val("status", data, 32'(trk_frame));
          check_val("pslverr", 32'(err), 32'd0);
        end
        4'h4, 4'h6: begin
          if (op == 4'h6) begin
            pix = model[row * c_cols + col];
            if (!rgb_on)
              pix = {3{pix[7:4]}};
          end else
            pix = vec[i][11:0];
          wait_pixel(frm, col, row, missed, seen);
          assert (!missed) else begin
            $display("probe at column %0d row %0d frame %0d came too late, pixel already shown",
                     col, row, frm);
            test_err = 1;
          end
          if (!missed)
            check_val($sformatf("rgb(%0d,%0d)", col, row), 32'(seen), 32'(pix));
        end
        default: begin
          $display("unknown vector op %0h on line %0d", op, i);
          test_err = 1;
        end
      endcase
      tests_run++;
      tests_failed += test_err;
      $display("test %0d op %0h %s", tests_run, op, test_err ? "failed" : "ok");
    end

    test_err = 0;
    assert (trk_on && sync_errs == 0) else begin
      $display("raster tracker saw %0d sync mismatches or never locked", sync_errs);
      test_err = 1;
    end
    tests_run++;
    tests_failed += test_err;
    $display("test %0d sync timing %s", tests_run, test_err ? "failed" : "ok");

    test_err = 0;
    assert (u_dut.u_assert.fail_cnt == 0) else begin
      $display("bound assertions failed %0d times", u_dut.u_assert.fail_cnt);
      test_err = 1;
    end
    tests_run++;
    tests_failed += test_err;
    $display("test %0d bound assertions %s", tests_run, test_err ? "failed" : "ok");

    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog sized from the frames and apb traffic in the vectors
  initial begin
    wait (vec_loaded);
    #(limit_ns);
    $display("timeout after %0d ns, tests did not complete", limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* vga_vectors.txt */
// probes: op frame pad col row pad rgb      apb: op reg pad data
// op 1 write, 2 read, 3 read with pslverr, 4 probe rgb, 5 random fill, 6 probe buffer pixel, 7 frame step, f end
2_C_000000_00000000
1_0_000000_00000003
2_0_000000_00000003
1_4_000000_00000123
2_4_000000_00000123
2_8_000000_00000000
3_2_000000_00000000
3_E_000000_00000000
1_0_000000_00000001
1_4_000000_00000000
5_0_000000_000012C0
2_4_000000_00000000
7_0_000000_00000000
// frame 2, colour mode
6_2_0_000_000_0000_000
6_2_0_001_000_0000_000
6_2_0_04F_000_0000_000
6_2_0_000_001_0000_000
4_2_0_140_005_0000_808
4_2_0_050_00A_0000_088
6_2_0_028_01E_0000_000
6_2_0_04F_03B_0000_000
4_2_0_005_03C_0000_088
4_2_0_064_064_0000_000
4_2_0_12C_078_0000_880
4_2_0_0A0_0C8_0000_880
4_2_0_1F4_0F0_0000_808
4_2_0_008_100_0000_FFF
4_2_0_00E_100_0000_000
4_2_0_010_100_0000_FFF
4_2_0_011_100_0000_000
4_2_0_009_101_0000_000
4_2_0_00E_101_0000_FFF
4_2_0_27F_1DF_0000_000
// frame 3, grey mode
1_0_000000_00000000
6_3_0_002_000_0000_000
6_3_0_028_01E_0000_000
4_3_0_008_100_0000_FFF
4_3_0_009_100_0000_000
4_3_0_008_102_0000_000
4_3_0_00A_102_0000_FFF
// frame 4, colour bars
1_0_000000_00000003
4_4_0_005_000_0000_000
4_4_0_00F_000_0000_00F
4_4_0_019_003_0000_0F0
4_4_0_023_003_0000_0FF
4_4_0_02D_00A_0000_F00
4_4_0_037_00A_0000_F0F
4_4_0_041_014_0000_FF0
4_4_0_04B_03B_0000_FFF
4_4_0_008_100_0000_FFF
4_4_0_010_100_0000_FFF
4_4_0_017_100_0000_000
4_4_0_010_102_0000_000
4_4_0_013_102_0000_FFF
F_0_000000_00000000

/* files.f */
vga_pkg.sv
vga_sync.sv
frame_buffer.sv
apb_regs.sv
test_pattern.sv
vga_display.sv
vga_top.sv
vga_assertions.sv
tb_vga_top.sv

/* Makefile */
# verilator build and run of the vga testbench

SRCS := $(shell cat files.f)

obj_dir/Vtb_vga_top: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_vga_top -f files.f

run: obj_dir/Vtb_vga_top
	@out="$$(./obj_dir/Vtb_vga_top)"; echo "$$out"; echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf obj_dir

.PHONY: run clean
